// File: vlog.f
+incdir+hdl
hdl/a2card_pkg.sv
hdl/card_config_regs.sv
hdl/bus_response_arbiter.sv
hdl/audio_mixer.sv
hdl/card_glue_top.sv
testbench/tb_clock_gen.sv
testbench/tb_card_glue.sv

// File: testbench/tb_card_glue.sv
// Directed tests for the card glue top level
// Read priority, interrupts, mixing, credits, speaker and mute

`timescale 1ns/1ns

`include "a2card_consts.svh"

module tb_card_glue;
    import a2card_pkg::*;

    localparam int CLK_PERIOD_NS = 4;
    localparam int RD_ITER       = 24;
    localparam int MIX_ITER      = 16;
    localparam int HOLD_CYCLES   = 3 * `A2C_DEBOUNCE_CYCLES;
    // Rough cycle budget of each test with some slack
    localparam int RD_CYCLES     = (RD_ITER + 1) * 2;
    localparam int IRQ_CYCLES    = (`A2C_NUM_CARDS + 1) * 2;
    localparam int MIX_CYCLES    = (MIX_ITER + 2) * 6;
    localparam int CREDIT_CYCLES = 32;
    localparam int SPK_CYCLES    = 80;
    localparam int MUTE_CYCLES   = 4 * HOLD_CYCLES + 24;
    localparam int RUN_CYCLES    = 10 + RD_CYCLES + IRQ_CYCLES + MIX_CYCLES
                                 + CREDIT_CYCLES + SPK_CYCLES + MUTE_CYCLES + 200;

    logic                      clk_logic_w;
    logic                      arst_n_w;
    card_resp_vec_t            card_resp_i;
    logic [`A2C_NUM_CARDS-1:0] irq_n_i;
    bus_access_t               bus_i;
    audio_src_t                audio_src_i;
    logic                      sample_tick_i;
    logic                      button_i;
    logic                      credit_return_i;
    dip_t                      dip_n_i;
    logic                      data_out_en_o;
    bus_data_t                 data_out_o;
    logic                      irq_n_o;
    stereo_sample_t            sample_o;
    logic                      sample_valid_o;

    integer seed;
    int     errors;
    int     checks;
    int     tests_run;
    int     tests_failed;
    logic   spk_level;    // Expected speaker bit
    logic   spk_enable;   // Expected speaker_en after sync
    logic   muted;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(10)) u_clk (
        .clk_logic_w (clk_logic_w),
        .arst_n_o    (arst_n_w)
    );

    card_glue_top u_dut (
        .clk_logic_w     (clk_logic_w),
        .arst_n_i        (arst_n_w),
        .card_resp_i     (card_resp_i),
        .irq_n_i         (irq_n_i),
        .bus_i           (bus_i),
        .audio_src_i     (audio_src_i),
        .sample_tick_i   (sample_tick_i),
        .button_i        (button_i),
        .credit_return_i (credit_return_i),
        .dip_n_i         (dip_n_i),
        .data_out_en_o   (data_out_en_o),
        .data_out_o      (data_out_o),
        .irq_n_o         (irq_n_o),
        .sample_o        (sample_o),
        .sample_valid_o  (sample_valid_o)
    );

    task automatic compare_data(input string name, input bus_data_t exp, input bus_data_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected 0x%h, actual 0x%h", name, exp, act);
        end
    endtask

    task automatic verify_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic match_sample(input string name, input stereo_sample_t exp,
                                input stereo_sample_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected L=%0d R=%0d, actual L=%0d R=%0d",
                     name, exp.left, exp.right, act.left, act.right);
        end
    endtask

    // One side of the mix in plain integer math with clipping
    function automatic audio_sample_t mix_expect(audio_sample_t glu, psg_level_t mb,
                                                 psg_level_t ssp, logic spk);
        int total;
        total = int'(glu) + int'(mb) * 8 + int'(ssp) * 8 + (spk ? 4096 : 0);
        if (total > 32767)
            total = 32767;
        else if (total < -32768)
            total = -32768;
        return audio_sample_t'(total);
    endfunction

    task automatic report_test(input string name, input int errs_at_start);
        tests_run++;
        if (errors > errs_at_start) begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - errs_at_start);
        end else begin
            $display("%s: passed", name);
        end
    endtask

    // Ticks and checks the sample one cycle later before handing the credit back
    task automatic take_sample(input string name, input audio_src_t src);
        stereo_sample_t exp;
        logic           spk_eff;
        spk_eff = spk_level & spk_enable;
        exp = '0;
        if (!muted) begin
            exp.left  = mix_expect(src.glu_l, src.mb_l, src.ssp, spk_eff);
            exp.right = mix_expect(src.glu_r, src.mb_r, src.ssp, spk_eff);
        end
        @(posedge clk_logic_w);
        audio_src_i   <= src;
        sample_tick_i <= 1'b1;
        @(posedge clk_logic_w);
        sample_tick_i <= 1'b0;
        @(negedge clk_logic_w);
        verify_bit({name, " valid"}, 1'b1, sample_valid_o);
        match_sample(name, exp, sample_o);
        @(posedge clk_logic_w);
        credit_return_i <= 1'b1;
        @(posedge clk_logic_w);
        credit_return_i <= 1'b0;
    endtask

    task automatic access_bus(input bus_addr_t addr, input logic rw_n);
        @(posedge clk_logic_w);
        bus_i.strobe <= 1'b1;
        bus_i.rw_n   <= rw_n;
        bus_i.addr   <= addr;
        @(posedge clk_logic_w);
        bus_i.strobe <= 1'b0;
        if (addr == `A2C_SPEAKER_ADDR)
            spk_level = ~spk_level;
    endtask

    task automatic hold_button(input logic level, input int cycles);
        @(posedge clk_logic_w);
        button_i <= level;
        repeat (cycles) @(posedge clk_logic_w);
    endtask

    task automatic read_priority();
        card_resp_vec_t resp;
        bus_data_t      exp_data;
        logic           exp_en;
        logic [31:0]    rnd;
        int             errs_at_start;
        errs_at_start = errors;
        for (int i = 0; i < RD_ITER; i++) begin
            exp_en   = 1'b0;
            exp_data = '0;
            for (int c = 0; c < `A2C_NUM_CARDS; c++) begin
                rnd = $random(seed);
                resp[c].rd_en = (i != 0) && (rnd[1:0] == 2'b00);
                resp[c].data  = rnd[15:8];
                if (!exp_en && resp[c].rd_en) begin    // First active card wins
                    exp_en   = 1'b1;
                    exp_data = resp[c].data;
                end
            end
            @(posedge clk_logic_w);
            card_resp_i <= resp;
            @(posedge clk_logic_w);
            @(negedge clk_logic_w);
            verify_bit($sformatf("read_priority en #%0d", i), exp_en, data_out_en_o);
            compare_data($sformatf("read_priority data #%0d", i), exp_data, data_out_o);
        end
        report_test("read_priority", errs_at_start);
    endtask

    task automatic irq_combine();
        logic [`A2C_NUM_CARDS-1:0] lines;
        int                        errs_at_start;
        errs_at_start = errors;
        for (int c = 0; c <= `A2C_NUM_CARDS; c++) begin
            lines = '1;
            if (c < `A2C_NUM_CARDS)
                lines[c] = 1'b0;
            @(posedge clk_logic_w);
            irq_n_i <= lines;
            @(posedge clk_logic_w);
            @(negedge clk_logic_w);
            // Only the final all-high step leaves the line released
            verify_bit($sformatf("irq_combine #%0d", c), c == `A2C_NUM_CARDS, irq_n_o);
        end
        report_test("irq_combine", errs_at_start);
    endtask

    task automatic mix_random();
        audio_src_t  src;
        logic [31:0] rnd;
        int          errs_at_start;
        errs_at_start = errors;
        for (int i = 0; i < MIX_ITER; i++) begin
            rnd = $random(seed);
            src.glu_l = rnd[15:0];
            src.glu_r = rnd[31:16];
            rnd = $random(seed);
            src.mb_l = rnd[9:0];
            src.mb_r = rnd[19:10];
            src.ssp  = rnd[29:20];
            take_sample("mix_random", src);
        end
        // Clip high on the left and the most negative value on the right
        src = '{glu_l: 16'sh7fff, glu_r: 16'sh8000, mb_l: 10'h3ff, mb_r: 10'h0, ssp: 10'h0};
        take_sample("mix_random clip", src);
        src = '{glu_l: 16'sd16399, glu_r: -16'sd16384, mb_l: 10'h3ff, mb_r: 10'h0,
                ssp: 10'h3ff};
        take_sample("mix_random edge", src);    // Left lands exactly on the maximum
        report_test("mix_random", errs_at_start);
    endtask

    task automatic credit_backpressure();
        audio_src_t src;
        int         errs_at_start;
        errs_at_start = errors;
        src = '{glu_l: 16'sd300, glu_r: -16'sd300, mb_l: 10'd5, mb_r: 10'd7, ssp: 10'd1};
        @(posedge clk_logic_w);
        audio_src_i   <= src;
        sample_tick_i <= 1'b1;
        for (int i = 0; i < 7; i++) begin
            @(posedge clk_logic_w);
            if (i == 5)
                sample_tick_i <= 1'b0;
            @(negedge clk_logic_w);
            verify_bit($sformatf("credit_backpressure tick %0d", i), i < 4, sample_valid_o);
        end
        @(posedge clk_logic_w);
        credit_return_i <= 1'b1;
        @(posedge clk_logic_w);
        credit_return_i <= 1'b0;
        take_sample("credit_backpressure", src);
        @(posedge clk_logic_w);
        credit_return_i <= 1'b1;    // Refill the other three
        repeat (3) @(posedge clk_logic_w);
        credit_return_i <= 1'b0;
        report_test("credit_backpressure", errs_at_start);
    endtask

    task automatic speaker_toggle();
        audio_src_t src;
        int         errs_at_start;
        errs_at_start = errors;
        src = '{glu_l: 16'sd1000, glu_r: -16'sd2000, mb_l: 10'd100, mb_r: 10'd200, ssp: 10'd50};
        @(posedge clk_logic_w);
        dip_n_i <= 4'b1101;
        repeat (4) @(posedge clk_logic_w);
        spk_enable = 1'b1;
        take_sample("speaker_toggle off", src);
        access_bus(`A2C_SPEAKER_ADDR, 1'b0);
        take_sample("speaker_toggle write", src);
        access_bus(16'hC031, 1'b1);
        take_sample("speaker_toggle other", src);
        access_bus(16'h0030, 1'b0);
        access_bus(`A2C_SPEAKER_ADDR, 1'b1);
        take_sample("speaker_toggle read", src);
        access_bus(`A2C_SPEAKER_ADDR, 1'b0);
        take_sample("speaker_toggle on", src);
        @(posedge clk_logic_w);
        dip_n_i <= 4'b1111;
        repeat (4) @(posedge clk_logic_w);
        spk_enable = 1'b0;
        take_sample("speaker_toggle disabled", src);
        report_test("speaker_toggle", errs_at_start);
    endtask

    task automatic mute_toggle();
        audio_src_t src;
        int         errs_at_start;
        errs_at_start = errors;
        src = '{glu_l: -16'sd1234, glu_r: 16'sd4321, mb_l: 10'd300, mb_r: 10'd12, ssp: 10'd99};
        hold_button(1'b1, HOLD_CYCLES);
        muted = 1'b1;
        take_sample("mute_toggle muted", src);
        hold_button(1'b0, HOLD_CYCLES);
        take_sample("mute_toggle released", src);    // Release keeps the mute
        hold_button(1'b1, HOLD_CYCLES);
        muted = 1'b0;
        hold_button(1'b0, HOLD_CYCLES);
        take_sample("mute_toggle unmuted", src);
        report_test("mute_toggle", errs_at_start);
    endtask

    initial begin
        #(RUN_CYCLES * CLK_PERIOD_NS);
        $display("Watchdog expired after %0d cycles, the tests did not finish", RUN_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        seed            = 32'hdc6c_5704;
        errors          = 0;
        checks          = 0;
        tests_run       = 0;
        tests_failed    = 0;
        spk_level       = 1'b0;
        spk_enable      = 1'b0;
        muted           = 1'b0;
        card_resp_i     = '0;
        irq_n_i         = '1;
        bus_i           = '0;
        audio_src_i     = '0;
        sample_tick_i   = 1'b0;
        button_i        = 1'b0;
        credit_return_i = 1'b0;
        dip_n_i         = '1;
        wait (arst_n_w === 1'b1);
        repeat (2) @(posedge clk_logic_w);
        read_priority();
        irq_combine();
        mix_random();
        credit_backpressure();
        speaker_toggle();
        mute_toggle();
        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

// File: testbench/tb_clock_gen.sv
// Clock and reset source for the testbench

`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 10
) (
    output logic clk_logic_w,
    output logic arst_n_o
);

    initial begin
        clk_logic_w = 1'b0;
        forever #(PERIOD_NS / 2) clk_logic_w = ~clk_logic_w;
    end

    initial begin
        arst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_logic_w);
        arst_n_o <= 1'b1;    // Released on a clock edge
    end

endmodule

// File: hdl/card_glue_top.sv
// Card glue top level
// Config registers, bus response arbiter and audio mixer

`timescale 1ns/1ns

`include "a2card_consts.svh"

module card_glue_top (
    input  logic                       clk_logic_w,
    input  logic                       arst_n_i,
    input  a2card_pkg::card_resp_vec_t card_resp_i,
    input  logic [`A2C_NUM_CARDS-1:0]  irq_n_i,
    input  a2card_pkg::bus_access_t    bus_i,
    input  a2card_pkg::audio_src_t     audio_src_i,
    input  logic                       sample_tick_i,
    input  logic                       button_i,
    input  logic                       credit_return_i,
    input  a2card_pkg::dip_t           dip_n_i,
    output logic                       data_out_en_o,
    output a2card_pkg::bus_data_t      data_out_o,
    output logic                       irq_n_o,
    output a2card_pkg::stereo_sample_t sample_o,
    output logic                       sample_valid_o
);
    import a2card_pkg::*;

    card_cfg_t cfg_w;    // Speaker enable and mute

    card_config_regs u_config (
        .clk_logic_w (clk_logic_w),
        .arst_n_i    (arst_n_i),
        .dip_n_i     (dip_n_i),
        .button_i    (button_i),
        .cfg_o       (cfg_w)
    );

    bus_response_arbiter u_arbiter (
        .clk_logic_w   (clk_logic_w),
        .arst_n_i      (arst_n_i),
        .card_resp_i   (card_resp_i),
        .irq_n_i       (irq_n_i),
        .data_out_en_o (data_out_en_o),
        .data_out_o    (data_out_o),
        .irq_n_o       (irq_n_o)
    );

    audio_mixer u_mixer (
        .clk_logic_w     (clk_logic_w),
        .arst_n_i        (arst_n_i),
        .bus_i           (bus_i),
        .audio_src_i     (audio_src_i),
        .cfg_i           (cfg_w),
        .sample_tick_i   (sample_tick_i),
        .credit_return_i (credit_return_i),
        .sample_o        (sample_o),
        .sample_valid_o  (sample_valid_o)
    );

endmodule

// File: hdl/audio_mixer.sv
// Speaker toggle, stereo mixer with saturation and credit-based output
// One sample issued per tick while the sink has room

`timescale 1ns/1ns

`include "a2card_consts.svh"

module audio_mixer (
    input  logic                       clk_logic_w,
    input  logic                       arst_n_i,
    input  a2card_pkg::bus_access_t    bus_i,
    input  a2card_pkg::audio_src_t     audio_src_i,
    input  a2card_pkg::card_cfg_t      cfg_i,
    input  logic                       sample_tick_i,
    input  logic                       credit_return_i,
    output a2card_pkg::stereo_sample_t sample_o,
    output logic                       sample_valid_o
);
    import a2card_pkg::*;

    localparam int SUM_W    = `A2C_AUDIO_W + 2;    // Headroom for four sources
    localparam int PSG_EXT  = `A2C_PSG_W + 3;
    localparam int CREDIT_W = $clog2(`A2C_AUDIO_CREDITS + 1);

    logic                speaker_q;
    logic [CREDIT_W-1:0] credit_q;
    logic                issue_w;
    logic                spk_on_w;
    stereo_sample_t      mix_w;
    stereo_sample_t      sample_q;
    logic                valid_q;

    // Sum one side and clip to the signed 16-bit range
    function automatic audio_sample_t mix_side(audio_sample_t glu, psg_level_t mb,
                                               psg_level_t ssp, logic spk);
        logic [SUM_W-1:0] sum;
        sum = {{(SUM_W - `A2C_AUDIO_W){glu[`A2C_AUDIO_W-1]}}, glu}
            + {{(SUM_W - PSG_EXT){1'b0}}, mb, 3'b000}
            + {{(SUM_W - PSG_EXT){1'b0}}, ssp, 3'b000}
            + (spk ? SUM_W'(4096) : SUM_W'(0));
        if (!sum[SUM_W-1] && (|sum[SUM_W-2:`A2C_AUDIO_W-1]))
            return {1'b0, {(`A2C_AUDIO_W-1){1'b1}}};    // Clip high
        else if (sum[SUM_W-1] && !(&sum[SUM_W-2:`A2C_AUDIO_W-1]))
            return {1'b1, {(`A2C_AUDIO_W-1){1'b0}}};    // Clip low
        else
            return sum[`A2C_AUDIO_W-1:0];
    endfunction

    // Reads and writes both flip the speaker
    always_ff @(posedge clk_logic_w or negedge arst_n_i) begin
        if (!arst_n_i)
            speaker_q <= 1'b0;
        else if (bus_i.strobe && (bus_i.addr == bus_addr_t'(`A2C_SPEAKER_ADDR)))
            speaker_q <= ~speaker_q;
    end

    assign spk_on_w = speaker_q & cfg_i.speaker_en;
    assign issue_w  = sample_tick_i && (credit_q != '0);    // Ticks at zero are dropped

    always_comb begin
        mix_w.left  = mix_side(audio_src_i.glu_l, audio_src_i.mb_l, audio_src_i.ssp, spk_on_w);
        mix_w.right = mix_side(audio_src_i.glu_r, audio_src_i.mb_r, audio_src_i.ssp, spk_on_w);
    end

    always_ff @(posedge clk_logic_w or negedge arst_n_i) begin
        if (!arst_n_i) begin
            credit_q <= CREDIT_W'(`A2C_AUDIO_CREDITS);
            valid_q  <= 1'b0;
        end else begin
            valid_q <= issue_w;
            case ({issue_w, credit_return_i})
                2'b10:   credit_q <= credit_q - CREDIT_W'(1);
                2'b01:   credit_q <= credit_q + CREDIT_W'(1);
                default: credit_q <= credit_q;    // Issue and return cancel
            endcase
        end
    end

    always_ff @(posedge clk_logic_w) begin
        if (issue_w)
            sample_q <= cfg_i.mute ? '0 : mix_w;
    end

    assign sample_o       = sample_q;
    assign sample_valid_o = valid_q;

    // Sink may only return credits for samples it holds
    a_no_return_when_full: assert property (@(posedge clk_logic_w) disable iff (!arst_n_i)
        credit_return_i |-> (credit_q < CREDIT_W'(`A2C_AUDIO_CREDITS)));

    a_no_issue_without_credit: assert property (@(posedge clk_logic_w) disable iff (!arst_n_i)
        sample_valid_o |-> ($past(credit_q) != '0));

endmodule

// File: hdl/bus_response_arbiter.sv
// Fixed-priority read data select and interrupt combine
// Registered, one cycle of latency

`timescale 1ns/1ns

`include "a2card_consts.svh"

module bus_response_arbiter (
    input  logic                       clk_logic_w,
    input  logic                       arst_n_i,
    input  a2card_pkg::card_resp_vec_t card_resp_i,
    input  logic [`A2C_NUM_CARDS-1:0]  irq_n_i,
    output logic                       data_out_en_o,
    output a2card_pkg::bus_data_t      data_out_o,
    output logic                       irq_n_o
);
    import a2card_pkg::*;

    logic      sel_en;
    bus_data_t sel_data;

    // Walk from lowest priority up so index 0 lands last
    always_comb begin
        sel_en   = 1'b0;
        sel_data = '0;
        for (int i = `A2C_NUM_CARDS - 1; i >= 0; i--) begin
            if (card_resp_i[i].rd_en) begin
                sel_en   = 1'b1;
                sel_data = card_resp_i[i].data;
            end
        end
    end

    always_ff @(posedge clk_logic_w or negedge arst_n_i) begin
        if (!arst_n_i) begin
            data_out_en_o <= 1'b0;
            data_out_o    <= '0;
            irq_n_o       <= 1'b1;    // No interrupt pending
        end else begin
            data_out_en_o <= sel_en;
            data_out_o    <= sel_data;
            irq_n_o       <= &irq_n_i;    // Any card low pulls the line
        end
    end

    // Idle bus must not carry stale card data
    a_idle_data_zero: assert property (@(posedge clk_logic_w) disable iff (!arst_n_i)
        !data_out_en_o |-> (data_out_o == '0));

endmodule

// File: hdl/card_config_regs.sv
// DIP switch synchronizer, button debouncer and mute toggle

`timescale 1ns/1ns

`include "a2card_consts.svh"

module card_config_regs (
    input  logic                  clk_logic_w,
    input  logic                  arst_n_i,
    input  a2card_pkg::dip_t      dip_n_i,
    input  logic                  button_i,
    output a2card_pkg::card_cfg_t cfg_o
);
    import a2card_pkg::*;

    localparam int CNT_W = $clog2(`A2C_DEBOUNCE_CYCLES + 1);

    dip_t            dip_sync1_q;
    dip_t            dip_sync2_q;
    logic            btn_sync1_q;
    logic            btn_sync2_q;
    debounce_state_t db_state_q;
    logic [CNT_W-1:0] db_cnt_q;
    logic            pressed_q;    // Debounced button level
    logic            mute_q;

    // Two-stage synchronizers, switches idle high
    always_ff @(posedge clk_logic_w or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dip_sync1_q <= '1;
            dip_sync2_q <= '1;
            btn_sync1_q <= 1'b0;
            btn_sync2_q <= 1'b0;
        end else begin
            dip_sync1_q <= dip_n_i;
            dip_sync2_q <= dip_sync1_q;
            btn_sync1_q <= button_i;
            btn_sync2_q <= btn_sync1_q;
        end
    end

    // Level must differ from the debounced one for the whole count
    always_ff @(posedge clk_logic_w or negedge arst_n_i) begin
        if (!arst_n_i) begin
            db_state_q <= DB_IDLE;
            db_cnt_q   <= '0;
            pressed_q  <= 1'b0;
            mute_q     <= 1'b0;
        end else begin
            case (db_state_q)
                DB_IDLE: begin
                    if (btn_sync2_q != pressed_q) begin
                        db_state_q <= DB_COUNT;
                        db_cnt_q   <= CNT_W'(1);
                    end
                end
                DB_COUNT: begin
                    if (btn_sync2_q == pressed_q) begin    // Bounce, start over
                        db_state_q <= DB_IDLE;
                        db_cnt_q   <= '0;
                    end else if (db_cnt_q == CNT_W'(`A2C_DEBOUNCE_CYCLES - 1)) begin
                        db_state_q <= DB_STABLE;
                        db_cnt_q   <= '0;
                        pressed_q  <= btn_sync2_q;
                    end else begin
                        db_cnt_q <= db_cnt_q + CNT_W'(1);
                    end
                end
                DB_STABLE: begin
                    db_state_q <= DB_IDLE;
                    if (pressed_q)
                        mute_q <= ~mute_q;    // Debounced rising edge
                end
                default: db_state_q <= DB_IDLE;
            endcase
        end
    end

    assign cfg_o = '{speaker_en: ~dip_sync2_q[1], mute: mute_q};

    a_db_cnt_bound: assert property (@(posedge clk_logic_w) disable iff (!arst_n_i)
        db_cnt_q <= CNT_W'(`A2C_DEBOUNCE_CYCLES));

endmodule

// File: hdl/a2card_pkg.sv
// Shared types for the card glue logic
// Bus responses, bus cycles, audio samples and configuration

`include "a2card_consts.svh"

package a2card_pkg;

    typedef logic [`A2C_DATA_W-1:0] bus_data_t;
    typedef logic [`A2C_ADDR_W-1:0] bus_addr_t;

    // Read response of one card function
    typedef struct packed {
        logic      rd_en;
        bus_data_t data;
    } card_resp_t;

    typedef card_resp_t [`A2C_NUM_CARDS-1:0] card_resp_vec_t;    // Index 0 wins

    typedef struct packed {
        logic      strobe;
        logic      rw_n;
        bus_addr_t addr;
    } bus_access_t;

    typedef logic signed [`A2C_AUDIO_W-1:0] audio_sample_t;
    typedef logic [`A2C_PSG_W-1:0] psg_level_t;    // Unsigned PSG output

    typedef struct packed {
        audio_sample_t left;
        audio_sample_t right;
    } stereo_sample_t;

    typedef struct packed {
        audio_sample_t glu_l;    // Ensoniq
        audio_sample_t glu_r;
        psg_level_t    mb_l;     // Mockingboard
        psg_level_t    mb_r;
        psg_level_t    ssp;      // SuperSprite, mono
    } audio_src_t;

    typedef struct packed {
        logic speaker_en;
        logic mute;
    } card_cfg_t;

    typedef logic [`A2C_DIP_W-1:0] dip_t;    // Active low

    typedef enum logic [1:0] {DB_IDLE, DB_COUNT, DB_STABLE} debounce_state_t;

endpackage

// File: hdl/a2card_consts.svh
// Widths, counts and addresses for the card glue logic
// Bus, audio, card count, credit depth, debounce length

`ifndef A2CARD_CONSTS_SVH
`define A2CARD_CONSTS_SVH

// Apple bus
`define A2C_DATA_W 8
`define A2C_ADDR_W 16

// Audio paths
`define A2C_AUDIO_W 16
`define A2C_PSG_W 10

`define A2C_DIP_W 4

// SuperSerial, SuperSprite, Mockingboard, Disk II, CardROM
`define A2C_NUM_CARDS 5

`define A2C_AUDIO_CREDITS 4    // Sink buffer depth
`define A2C_DEBOUNCE_CYCLES 16

`define A2C_SPEAKER_ADDR 16'hC030

`endif
